// ==== buzzer.f ====
source/BuzzerPkg.sv
source/StrobeGenerator.sv
source/SoundGenerator.sv
source/NoteQueue.sv
source/MelodySequencer.sv
source/WishboneRegisters.sv
source/BuzzerTop.sv
testbench/BuzzerTb.sv
testbench/BuzzerTop_assertions.sv

// ==== run.sh ====
#!/bin/sh
# Build the buzzer testbench with Verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module BuzzerTb -f buzzer.f -o BuzzerSim \
	> build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/BuzzerSim > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== source/BuzzerPkg.sv ====
// Buzzer package with the note and Wishbone types, the register map and the status layout.

package BuzzerPkg;

	// ========================================================================
	// payload and bus types
	// ========================================================================

	// one note as the host writes it. A zero half period is a rest.
	typedef struct packed {
		logic [15:0] DurationMs;
		logic [15:0] HalfPeriodUs;
	} NoteT;

	// request from the Wishbone classic host.
	typedef struct packed {
		logic        Cyc;
		logic        Stb;
		logic        We;
		logic [1:0]  Adr;
		logic [31:0] Dat;
		logic [3:0]  Sel;
	} WbReqT;

	// response back to the host. There is no ERR or RTY.
	typedef struct packed {
		logic        Ack;
		logic [31:0] Dat;
	} WbRspT;

	// ========================================================================
	// register map
	// ========================================================================

	localparam logic [1:0] AddrNote    = 2'd0;
	localparam logic [1:0] AddrStatus  = 2'd1;
	localparam logic [1:0] AddrControl = 2'd2;

	// status word layout.
	localparam int StatusBusyBit   = 0;
	localparam int StatusEmptyBit  = 1;
	localparam int StatusFullBit   = 2;
	localparam int StatusLevelLsb  = 8;
	localparam int StatusPlayedLsb = 16;
	localparam int StatusDropLsb   = 24;

	// a one in this bit of the control word stops the player.
	localparam int ControlStopBit = 0;

endpackage

// ==== source/BuzzerTop.sv ====
// Buzzer top level joining the register slave, note queue, sequencer and sound generator.

`timescale 1ns/1ps

module BuzzerTop #(
	parameter int ClockHz    = 10_000_000,
	parameter int QueueDepth = 8
)(
	input  logic             Clock,
	input  logic             Reset,
	input  BuzzerPkg::WbReqT WbReq_i,
	output BuzzerPkg::WbRspT WbRsp_o,
	output logic             SoundWave_o,
	output logic             Busy_o
);

	logic            PushValid;
	BuzzerPkg::NoteT PushNote;
	logic            Stop;
	logic            Full;
	logic            Empty;
	logic [7:0]      Level;
	BuzzerPkg::NoteT HeadNote;
	logic            Pop;
	logic            Start;
	BuzzerPkg::NoteT StartNote;
	logic            Done;
	logic [7:0]      Played;

	WishboneRegisters #(
		.QueueDepth (QueueDepth)
	) i_WishboneRegisters (
		.Clock       (Clock),
		.Reset       (Reset),
		.WbReq_i     (WbReq_i),
		.WbRsp_o     (WbRsp_o),
		.Full_i      (Full),
		.Empty_i     (Empty),
		.Level_i     (Level),
		.Busy_i      (Busy_o),
		.Played_i    (Played),
		.PushValid_o (PushValid),
		.PushNote_o  (PushNote),
		.Stop_o      (Stop)
	);

	NoteQueue #(
		.QueueDepth (QueueDepth)
	) i_NoteQueue (
		.Clock      (Clock),
		.Reset      (Reset),
		.Push_i     (PushValid),
		.PushNote_i (PushNote),
		.Pop_i      (Pop),
		.Flush_i    (Stop),
		.HeadNote_o (HeadNote),
		.Empty_o    (Empty),
		.Full_o     (Full),
		.Level_o    (Level)
	);

	MelodySequencer i_MelodySequencer (
		.Clock       (Clock),
		.Reset       (Reset),
		.Empty_i     (Empty),
		.HeadNote_i  (HeadNote),
		.Busy_i      (Busy_o),
		.Done_i      (Done),
		.Pop_o       (Pop),
		.Start_o     (Start),
		.StartNote_o (StartNote),
		.Played_o    (Played)
	);

	SoundGenerator #(
		.ClockHz (ClockHz)
	) i_SoundGenerator (
		.Clock       (Clock),
		.Reset       (Reset),
		.Start_i     (Start),
		.Finish_i    (Stop),
		.Note_i      (StartNote),
		.SoundWave_o (SoundWave_o),
		.Busy_o      (Busy_o),
		.Done_o      (Done)
	);

endmodule

// ==== source/MelodySequencer.sv ====
// Melody sequencer that feeds queued notes to the sound generator one at a time.

`timescale 1ns/1ps

module MelodySequencer (
	input  logic            Clock,
	input  logic            Reset,
	input  logic            Empty_i,
	input  BuzzerPkg::NoteT HeadNote_i,
	input  logic            Busy_i,
	input  logic            Done_i,
	output logic            Pop_o,
	output logic            Start_o,
	output BuzzerPkg::NoteT StartNote_o,
	output logic [7:0]      Played_o
);

	logic Pending;
	logic [7:0] PlayedCount;

	// a note is taken only when the player is idle and no start is in flight.
	assign Pop_o       = !Empty_i && !Busy_i && !Pending;
	assign Start_o     = Pop_o;
	assign StartNote_o = HeadNote_i;

	// pending covers the cycle right after a start.
	// This keeps two notes from starting back to back before busy is seen.
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Pending <= 1'b0;
		end else begin
			Pending <= Pop_o;
		end
	end

	// every finished or stopped note counts as played. The counter wraps.
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			PlayedCount <= '0;
		end else if (Done_i) begin
			PlayedCount <= PlayedCount + 1'b1;
		end
	end

	assign Played_o = PlayedCount;

endmodule

// ==== source/NoteQueue.sv ====
// Note queue, a synchronous FIFO of notes with a fill level and a one-cycle flush.

`timescale 1ns/1ps

module NoteQueue #(
	parameter int QueueDepth = 8
)(
	input  logic            Clock,
	input  logic            Reset,
	input  logic            Push_i,
	input  BuzzerPkg::NoteT PushNote_i,
	input  logic            Pop_i,
	input  logic            Flush_i,
	output BuzzerPkg::NoteT HeadNote_o,
	output logic            Empty_o,
	output logic            Full_o,
	output logic [7:0]      Level_o
);

	// the depth is a power of two, so the pointers wrap on their own.
	localparam int PtrWidth = $clog2(QueueDepth);

	BuzzerPkg::NoteT     Mem [QueueDepth];
	logic [PtrWidth-1:0] WritePtr;
	logic [PtrWidth-1:0] ReadPtr;
	logic [PtrWidth:0]   Count;
	logic                DoPush;
	logic                DoPop;

	assign DoPush = Push_i && !Full_o;
	assign DoPop  = Pop_i && !Empty_o;

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			WritePtr <= '0;
			ReadPtr  <= '0;
			Count    <= '0;
		end else if (Flush_i) begin
			WritePtr <= '0;
			ReadPtr  <= '0;
			Count    <= '0;
		end else begin
			if (DoPush) begin
				WritePtr <= WritePtr + 1'b1;
			end
			if (DoPop) begin
				ReadPtr <= ReadPtr + 1'b1;
			end
			// a push and a pop together leave the count as it is.
			if (DoPush && !DoPop) begin
				Count <= Count + 1'b1;
			end else if (DoPop && !DoPush) begin
				Count <= Count - 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (DoPush) begin
			Mem[WritePtr] <= PushNote_i;
		end
	end

	assign HeadNote_o = Mem[ReadPtr];
	assign Empty_o    = (Count == '0);
	assign Full_o     = (Count == (PtrWidth + 1)'(QueueDepth));
	assign Level_o    = 8'(Count);

endmodule

// ==== source/SoundGenerator.sv ====
// Sound generator that plays one note as a square wave for its duration.

`timescale 1ns/1ps

module SoundGenerator #(
	parameter int ClockHz = 10_000_000
)(
	input  logic              Clock,
	input  logic              Reset,
	input  logic              Start_i,
	input  logic              Finish_i,
	input  BuzzerPkg::NoteT   Note_i,
	output logic              SoundWave_o,
	output logic              Busy_o,
	output logic              Done_o
);

	logic        TickEnable;
	logic        TickMicro;
	logic        TickMilli;
	logic [15:0] DurationTimer;
	logic        BusyPrevious;
	logic        Signal;
	logic [15:0] HalfPeriodCopy;
	logic [15:0] HalfPeriodTimer;

	// both tick sources run from the start strobe until the note ends.
	assign TickEnable = Busy_o || Start_i;

	StrobeGenerator #(
		.ClockHz  (ClockHz),
		.PeriodUs (1)
	) i_StrobeMicro (
		.Clock    (Clock),
		.Reset    (Reset),
		.Enable_i (TickEnable),
		.Strobe_o (TickMicro)
	);

	StrobeGenerator #(
		.ClockHz  (ClockHz),
		.PeriodUs (1000)
	) i_StrobeMilli (
		.Clock    (Clock),
		.Reset    (Reset),
		.Enable_i (TickEnable),
		.Strobe_o (TickMilli)
	);

	// ========================================================================
	// duration timer
	// ========================================================================

	// finish wins over a start in the same cycle, so a stop also drops a note
	// that is being popped right then.
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			DurationTimer <= '0;
		end else if (Finish_i) begin
			DurationTimer <= '0;
		end else if (Start_i) begin
			DurationTimer <= Note_i.DurationMs;
		end else if (Busy_o && TickMilli) begin
			DurationTimer <= DurationTimer - 1'b1;
		end
	end

	assign Busy_o = |DurationTimer;

	// done marks the falling edge of busy.
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			BusyPrevious <= 1'b0;
		end else begin
			BusyPrevious <= Busy_o;
		end
	end

	assign Done_o = !Busy_o && BusyPrevious;

	// ========================================================================
	// square wave
	// ========================================================================

	// each level is held for HalfPeriodUs+1 microsecond ticks.
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Signal          <= 1'b0;
			HalfPeriodCopy  <= '0;
			HalfPeriodTimer <= '0;
		end else if (Start_i) begin
			Signal          <= 1'b0;
			HalfPeriodCopy  <= Note_i.HalfPeriodUs;
			HalfPeriodTimer <= Note_i.HalfPeriodUs;
		end else if (HalfPeriodCopy == '0) begin
			// a rest keeps the wave low.
			Signal <= 1'b0;
		end else if (Busy_o && TickMicro) begin
			if (HalfPeriodTimer == '0) begin
				Signal          <= ~Signal;
				HalfPeriodTimer <= HalfPeriodCopy;
			end else begin
				HalfPeriodTimer <= HalfPeriodTimer - 1'b1;
			end
		end
	end

	assign SoundWave_o = Busy_o && Signal;

endmodule

// ==== source/StrobeGenerator.sv ====
// Strobe generator giving a one-cycle pulse every PeriodUs microseconds while enabled.

`timescale 1ns/1ps

module StrobeGenerator #(
	parameter int ClockHz  = 10_000_000,
	parameter int PeriodUs = 1
)(
	input  logic Clock,
	input  logic Reset,
	input  logic Enable_i,
	output logic Strobe_o
);

	// number of clock cycles in one strobe period.
	localparam int CyclesPerUs = ClockHz / 1_000_000;
	localparam int Cycles      = CyclesPerUs * PeriodUs;
	localparam int CountWidth  = (Cycles > 1) ? $clog2(Cycles) : 1;

	localparam logic [CountWidth-1:0] LastCount = CountWidth'(Cycles - 1);

	logic [CountWidth-1:0] Count;

	// the counter only runs while enabled and restarts from zero when disabled.
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Count <= '0;
		end else if (!Enable_i || Count == LastCount) begin
			Count <= '0;
		end else begin
			Count <= Count + 1'b1;
		end
	end

	// a disabled generator never strobes, even on the terminal count.
	assign Strobe_o = Enable_i && (Count == LastCount);

endmodule

// ==== source/WishboneRegisters.sv ====
// Wishbone classic register slave for note writes, status reads and the stop command.

`timescale 1ns/1ps

module WishboneRegisters #(
	parameter int QueueDepth = 8
)(
	input  logic             Clock,
	input  logic             Reset,
	input  BuzzerPkg::WbReqT WbReq_i,
	output BuzzerPkg::WbRspT WbRsp_o,
	input  logic             Full_i,
	input  logic             Empty_i,
	input  logic [7:0]       Level_i,
	input  logic             Busy_i,
	input  logic [7:0]       Played_i,
	output logic             PushValid_o,
	output BuzzerPkg::NoteT  PushNote_o,
	output logic             Stop_o
);

	logic        Active;
	logic        Accept;
	logic        AckReg;
	logic        NoteWrite;
	logic        StopWrite;
	logic        QueueFull;
	logic [7:0]  DropCount;
	logic [31:0] ReadData;
	logic [31:0] RspDat;

	// ========================================================================
	// bus handshake and decode
	// ========================================================================

	assign Active = WbReq_i.Cyc && WbReq_i.Stb;

	// an access is taken once, in the cycle before ack rises.
	assign Accept = Active && !AckReg;

	assign NoteWrite = Accept && WbReq_i.We && (WbReq_i.Adr == BuzzerPkg::AddrNote);
	assign StopWrite = Accept && WbReq_i.We && (WbReq_i.Adr == BuzzerPkg::AddrControl)
		&& WbReq_i.Dat[BuzzerPkg::ControlStopBit];

	// a push still on its way to the queue takes the last free slot.
	assign QueueFull = Full_i || (PushValid_o && Level_i == 8'(QueueDepth - 1));

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			AckReg      <= 1'b0;
			PushValid_o <= 1'b0;
			Stop_o      <= 1'b0;
			DropCount   <= '0;
		end else begin
			AckReg      <= Accept;
			PushValid_o <= NoteWrite && !QueueFull;
			Stop_o      <= StopWrite;
			if (NoteWrite && QueueFull) begin
				DropCount <= DropCount + 1'b1;
			end
		end
	end

	// the note and the read word are captured on the edge that raises ack.
	always_ff @(posedge Clock) begin
		if (NoteWrite) begin
			PushNote_o <= BuzzerPkg::NoteT'(WbReq_i.Dat);
		end
		if (Accept) begin
			RspDat <= WbReq_i.We ? '0 : ReadData;
		end
	end

	// ========================================================================
	// read mux
	// ========================================================================

	// only the status address returns data.
	always_comb begin
		ReadData = '0;
		if (WbReq_i.Adr == BuzzerPkg::AddrStatus) begin
			ReadData[BuzzerPkg::StatusBusyBit]          = Busy_i;
			ReadData[BuzzerPkg::StatusEmptyBit]         = Empty_i;
			ReadData[BuzzerPkg::StatusFullBit]          = Full_i;
			ReadData[BuzzerPkg::StatusLevelLsb +: 8]    = Level_i;
			ReadData[BuzzerPkg::StatusPlayedLsb +: 8]   = Played_i;
			ReadData[BuzzerPkg::StatusDropLsb +: 8]     = DropCount;
		end
	end

	assign WbRsp_o.Ack = AckReg;
	assign WbRsp_o.Dat = RspDat;

endmodule

// ==== testbench/BuzzerTb.sv ====
// Buzzer testbench that runs scripted Wishbone accesses and measures the tones played.

`timescale 1ns/1ps

module BuzzerTb;

	localparam int ClockHz     = 2_000_000;
	localparam int QueueDepth  = 8;
	localparam int CyclesPerUs = ClockHz / 1_000_000;
	localparam int CyclesPerMs = ClockHz / 1000;
	localparam int AckTimeout  = 16;
	localparam int IdlePolls   = 40_000;
	localparam int MaxVectors  = 64;

	localparam logic [7:0] OpEnd    = 8'h00;
	localparam logic [7:0] OpNote   = 8'h01;
	localparam logic [7:0] OpBurst  = 8'h02;
	localparam logic [7:0] OpStop   = 8'h03;
	localparam logic [7:0] OpStatus = 8'h04;
	localparam logic [7:0] OpIdle   = 8'h05;
	localparam logic [7:0] OpPlayed = 8'h06;
	localparam logic [7:0] OpDrops  = 8'h07;

	// one line of the vector file.
	typedef struct packed {
		logic [7:0]  Op;
		logic [31:0] A;
		logic [31:0] B;
	} VectorT;

	logic             Clock;
	logic             Reset;
	BuzzerPkg::WbReqT WbReq;
	BuzzerPkg::WbRspT WbRsp;
	logic             SoundWave;
	logic             Busy;

	logic [71:0] Vectors [MaxVectors];
	int          Checks = 0;
	int          ValueErrors = 0;
	int          OtherErrors = 0;
	bit          Aborted = 1'b0;
	int          BurstWrites = 0;

	// measurements of each finished note, in the order the notes ended.
	int unsigned BusyLenQ [$];
	int unsigned GapQ [$];
	bit          GapBadQ [$];
	bit          WaveHighQ [$];

	BuzzerTop #(
		.ClockHz    (ClockHz),
		.QueueDepth (QueueDepth)
	) i_BuzzerTop (
		.Clock       (Clock),
		.Reset       (Reset),
		.WbReq_i     (WbReq),
		.WbRsp_o     (WbRsp),
		.SoundWave_o (SoundWave),
		.Busy_o      (Busy)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// ========================================================================
	// edge timing monitor
	// ========================================================================

	int unsigned CycleNow = 0;
	int unsigned BusyStart;
	int unsigned LastEdge;
	int unsigned FirstGap;
	bit          EdgeSeen;
	bit          GapBad;
	bit          WaveHigh;
	logic        PrevBusy;
	logic        PrevWave;

	// edges are timed between toggles inside one note. The first toggle after the
	// start and the drop at the end of the note are not part of the spacing.
	always @(negedge Clock) begin
		CycleNow = CycleNow + 1;
		if (!Reset) begin
			PrevBusy = 1'b0;
			PrevWave = 1'b0;
		end else begin
			if (Busy && !PrevBusy) begin
				BusyStart = CycleNow;
				EdgeSeen  = 1'b0;
				FirstGap  = 0;
				GapBad    = 1'b0;
				WaveHigh  = 1'b0;
			end else if (Busy && SoundWave != PrevWave) begin
				if (EdgeSeen && FirstGap == 0) begin
					FirstGap = CycleNow - LastEdge;
				end else if (EdgeSeen && CycleNow - LastEdge != FirstGap) begin
					GapBad = 1'b1;
				end
				EdgeSeen = 1'b1;
				LastEdge = CycleNow;
			end
			if (Busy && SoundWave) begin
				WaveHigh = 1'b1;
			end
			if (!Busy && PrevBusy) begin
				BusyLenQ.push_back(CycleNow - BusyStart);
				GapQ.push_back(FirstGap);
				GapBadQ.push_back(GapBad);
				WaveHighQ.push_back(WaveHigh);
			end
			PrevBusy = Busy;
			PrevWave = SoundWave;
		end
	end

	// turns the measurements of one note back into the note that should have made them.
	function automatic BuzzerPkg::NoteT MeasureNote(input int unsigned busyLen,
		input int unsigned gap, input bit gapBad, input bit waveHigh);
		BuzzerPkg::NoteT note;
		note.DurationMs = 16'((busyLen + CyclesPerMs - 1) / CyclesPerMs);
		if (gapBad) begin
			note.HalfPeriodUs = 16'hFFFF;
		end else if (gap == 0) begin
			note.HalfPeriodUs = waveHigh ? 16'hFFFF : 16'h0000;
		end else if ((gap % CyclesPerUs) != 0 || gap < 2 * CyclesPerUs) begin
			// one microsecond per level fits no note, since a zero half period is a rest.
			note.HalfPeriodUs = 16'hFFFF;
		end else begin
			note.HalfPeriodUs = 16'(gap / CyclesPerUs - 1);
		end
		return note;
	endfunction

	// ========================================================================
	// compare tasks
	// ========================================================================

	task automatic CheckStatus(input string name, input logic [31:0] expected,
		input logic [31:0] mask, input BuzzerPkg::WbRspT actual);
		Checks++;
		if ((actual.Dat & mask) !== (expected & mask)) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected & mask,
				actual.Dat & mask);
			ValueErrors++;
		end
	endtask

	task automatic CheckNote(input string name, input BuzzerPkg::NoteT expected,
		input BuzzerPkg::NoteT actual);
		Checks++;
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			ValueErrors++;
		end
	endtask

	task automatic CheckCount(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		Checks++;
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			ValueErrors++;
		end
	endtask

	// ========================================================================
	// bus and player tasks
	// ========================================================================

	// drives one Wishbone classic access on the falling edge and holds it until Ack.
	task automatic BusAccess(input logic we, input logic [1:0] adr, input logic [31:0] dat,
		output BuzzerPkg::WbRspT rsp);
		int waitCount;
		waitCount = 0;
		@(negedge Clock);
		WbReq.Cyc = 1'b1;
		WbReq.Stb = 1'b1;
		WbReq.We  = we;
		WbReq.Adr = adr;
		WbReq.Dat = dat;
		WbReq.Sel = 4'hF;
		do begin
			@(negedge Clock);
			waitCount++;
		end while (!WbRsp.Ack && waitCount < AckTimeout);
		rsp = WbRsp;
		if (!WbRsp.Ack) begin
			$display("no Ack within %0d cycles on an access to address %0d", AckTimeout, adr);
			OtherErrors++;
			Aborted = 1'b1;
		end
		WbReq = '0;
	endtask

	// polls the status word until the player is idle and the queue is empty.
	task automatic WaitIdle(input string name);
		BuzzerPkg::WbRspT rsp;
		int               polls;
		bit               idle;
		polls = 0;
		idle  = 1'b0;
		while (!idle && !Aborted && polls < IdlePolls) begin
			BusAccess(1'b0, BuzzerPkg::AddrStatus, '0, rsp);
			idle = !rsp.Dat[BuzzerPkg::StatusBusyBit] && rsp.Dat[BuzzerPkg::StatusEmptyBit];
			polls++;
		end
		if (!idle && !Aborted) begin
			$display("%s: the player did not go idle within %0d status reads", name, IdlePolls);
			OtherErrors++;
			Aborted = 1'b1;
		end
	endtask

	task automatic StopPlayer(input string name);
		BuzzerPkg::WbRspT rsp;
		int               waitCount;
		BusAccess(1'b1, BuzzerPkg::AddrControl, 32'h1, rsp);
		waitCount = 0;
		while (Busy && waitCount < 2) begin
			@(negedge Clock);
			waitCount++;
		end
		Checks++;
		if (Busy) begin
			$display("%s: Busy was still high two cycles after the stop write", name);
			OtherErrors++;
		end
		if (SoundWave) begin
			$display("%s: the wave was still high after the stop write", name);
			OtherErrors++;
		end
		// the monitor logs the cut note on this edge, and that note is not checked.
		@(negedge Clock);
		BusyLenQ.delete();
		GapQ.delete();
		GapBadQ.delete();
		WaveHighQ.delete();
	endtask

	task automatic RunVector(input int idx, input VectorT vec);
		BuzzerPkg::WbRspT rsp;
		string            name;
		logic [7:0]       dropsExpected;
		int               i;
		name = $sformatf("vector %0d", idx);
		case (vec.Op)
			OpNote: BusAccess(1'b1, BuzzerPkg::AddrNote, vec.A, rsp);
			OpBurst: begin
				BurstWrites = QueueDepth + int'(vec.A);
				for (i = 0; i < BurstWrites && !Aborted; i++) begin
					BusAccess(1'b1, BuzzerPkg::AddrNote, vec.B, rsp);
				end
			end
			OpStop: StopPlayer(name);
			OpStatus: begin
				BusAccess(1'b0, BuzzerPkg::AddrStatus, '0, rsp);
				CheckStatus(name, vec.A, vec.B, rsp);
			end
			OpIdle: begin
				WaitIdle(name);
				// a second read sees the played count after the last done pulse.
				BusAccess(1'b0, BuzzerPkg::AddrStatus, '0, rsp);
				CheckCount(name, vec.A[7:0], rsp.Dat[BuzzerPkg::StatusPlayedLsb +: 8]);
			end
			OpPlayed: begin
				if (BusyLenQ.size() == 0) begin
					$display("%s: no finished note was recorded", name);
					OtherErrors++;
				end else begin
					CheckNote(name, BuzzerPkg::NoteT'(vec.A), MeasureNote(BusyLenQ.pop_front(),
						GapQ.pop_front(), GapBadQ.pop_front(), WaveHighQ.pop_front()));
				end
			end
			OpDrops: begin
				BusAccess(1'b0, BuzzerPkg::AddrStatus, '0, rsp);
				dropsExpected = 8'(BurstWrites) - rsp.Dat[BuzzerPkg::StatusLevelLsb +: 8];
				CheckCount(name, dropsExpected, rsp.Dat[BuzzerPkg::StatusDropLsb +: 8]);
			end
			default: begin
				$display("%s: unknown command %h in the vector file", name, vec.Op);
				OtherErrors++;
				Aborted = 1'b1;
			end
		endcase
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		int     idx;
		VectorT vec;
		bit     endSeen;
		Reset = 1'b0;
		WbReq = '0;
		for (idx = 0; idx < MaxVectors; idx++) begin
			Vectors[idx] = '0;
		end
		$readmemh("testbench/buzzer_vectors.txt", Vectors);
		repeat (2) @(negedge Clock);
		Reset = 1'b1;

		vec = VectorT'(Vectors[0]);
		if (vec.Op == OpEnd) begin
			$display("no vectors were read from testbench/buzzer_vectors.txt");
			OtherErrors++;
		end
		idx     = 0;
		endSeen = 1'b0;
		while (idx < MaxVectors && !Aborted && !endSeen) begin
			vec = VectorT'(Vectors[idx]);
			if (vec.Op == OpEnd) begin
				endSeen = 1'b1;
			end else begin
				RunVector(idx, vec);
				idx++;
			end
		end

		$display("summary: %0d checks, %0d value errors, %0d other errors", Checks,
			ValueErrors, OtherErrors);
		if (ValueErrors == 0 && OtherErrors == 0 && Checks > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== testbench/BuzzerTop_assertions.sv ====
// Bound checks on the buzzer top level for the bus acknowledge, the done pulse and the wave.

`timescale 1ns/1ps

module BuzzerTopAssertions (
	input logic Clock,
	input logic Reset,
	input logic Ack_i,
	input logic Busy_i,
	input logic Done_i,
	input logic SoundWave_i
);

	// every access gets a single-cycle acknowledge.
	AckOneCycle: assert property (@(posedge Clock) disable iff (!Reset)
		Ack_i |=> !Ack_i)
		else $error("Ack stayed high for two cycles");

	// done only ends a note that was playing.
	DoneAfterBusy: assert property (@(posedge Clock) disable iff (!Reset)
		Done_i |-> $past(Busy_i))
		else $error("Done rose without Busy in the cycle before");

	WaveGated: assert property (@(posedge Clock) disable iff (!Reset)
		!Busy_i |-> !SoundWave_i)
		else $error("SoundWave was high while Busy was low");

endmodule

bind BuzzerTop BuzzerTopAssertions i_BuzzerTopAssertions (
	.Clock       (Clock),
	.Reset       (Reset),
	.Ack_i       (WbRsp_o.Ack),
	.Busy_i      (Busy_o),
	.Done_i      (Done),
	.SoundWave_i (SoundWave_o)
);

// ==== testbench/buzzer_vectors.txt ====
// columns: op, word A, word B. Ops are 01 note, 02 burst, 03 stop, 04 status (A expected,
// B mask), 05 idle (A played), 06 played note (A note), 07 drops, 00 end. Note is {ms, us}.
04_00000002_FFFFFFFF
// one note of 3 ms with a half period of 9 us.
01_00030009_00000000
05_00000001_00000000
06_00030009_00000000
// three notes back to back, status taken while the first one plays.
01_00020004_00000000
01_00020013_00000000
01_0003001F_00000000
04_00010201_FFFFFFFF
05_00000004_00000000
06_00020004_00000000
06_00020013_00000000
06_0003001F_00000000
// a rest of 2 ms.
01_00020000_00000000
05_00000005_00000000
06_00020000_00000000
// long note, overfill the queue behind it, then stop it.
01_00140009_00000000
02_00000002_00010009
04_00050805_00FFFFFF
07_00000000_00000000
03_00000000_00000000
04_00060002_00FFFFFF
00_00000000_00000000
